/* Bender.yml */
package:
  name: itch_parser

export_include_dirs:
  - include

sources:
  - hw/itch_pkg.sv
  - hw/itch_framer.sv
  - hw/itch_field_assembler.sv
  - hw/itch_msg_emitter.sv
  - hw/itch_parser.sv
  - target: test
    files:
      - test/itch_parser_checker.sv
      - test/itch_parser_tb.sv

/* hw/itch_field_assembler.sv */
`timescale 1ns/1ps
`include "itch_params.svh"

module itch_field_assembler
    import itch_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  itch_beat_t beat,
    input  logic       beat_strobe,
    input  logic       abort,
    output itch_msg_t  record
);

    localparam int NB_LOCATE = `ITCH_W_LOCATE / 8;
    localparam int NB_TRACK  = `ITCH_W_TRACK / 8;
    localparam int NB_TS     = `ITCH_W_TS / 8;
    localparam int NB_REF    = `ITCH_W_REF / 8;
    localparam int NB_SHARES = `ITCH_W_SHARES / 8;
    localparam int NB_STOCK  = `ITCH_W_STOCK / 8;
    localparam int NB_PRICE  = `ITCH_W_PRICE / 8;
    localparam int NB_MATCH  = `ITCH_W_MATCH / 8;

    // True when byte idx falls inside the field starting at ofs
    function automatic logic in_field(input logic [`ITCH_IDX_W-1:0] idx, input int ofs,
                                      input int nb);
        return (int'(idx) >= ofs) && (int'(idx) < ofs + nb);
    endfunction

    // Bit position of the byte lane, big-endian so the first byte lands on top
    function automatic int lane(input logic [`ITCH_IDX_W-1:0] idx, input int ofs, input int nb);
        return 8 * (ofs + nb - 1 - int'(idx));
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            record <= '0;
        end else if (beat_strobe && beat.first) begin
            record          <= '0;  // Unused fields stay zero from here on
            record.msg_type <= beat.data;
        end else if (abort) begin
            record <= '0;
        end else if (beat_strobe) begin
            if (beat.idx <= `ITCH_HDR_LAST) begin
                if (in_field(beat.idx, `ITCH_OFS_LOCATE, NB_LOCATE))
                    record.stock_locate[lane(beat.idx, `ITCH_OFS_LOCATE, NB_LOCATE) +: 8] <= beat.data;
                if (in_field(beat.idx, `ITCH_OFS_TRACK, NB_TRACK))
                    record.tracking_no[lane(beat.idx, `ITCH_OFS_TRACK, NB_TRACK) +: 8] <= beat.data;
                if (in_field(beat.idx, `ITCH_OFS_TS, NB_TS))
                    record.timestamp[lane(beat.idx, `ITCH_OFS_TS, NB_TS) +: 8] <= beat.data;
                if (in_field(beat.idx, `ITCH_OFS_REF, NB_REF))
                    record.order_ref_no[lane(beat.idx, `ITCH_OFS_REF, NB_REF) +: 8] <= beat.data;
            end else begin
                // Past the header the layout depends on the type
                case (beat.msg_type)
                    `ITCH_TYPE_A: begin
                        if (int'(beat.idx) == `ITCH_OFS_A_BUYSELL)
                            record.buy_sell <= beat.data;
                        if (in_field(beat.idx, `ITCH_OFS_A_SHARES, NB_SHARES))
                            record.shares[lane(beat.idx, `ITCH_OFS_A_SHARES, NB_SHARES) +: 8] <= beat.data;
                        if (in_field(beat.idx, `ITCH_OFS_A_STOCK, NB_STOCK))
                            record.stock[lane(beat.idx, `ITCH_OFS_A_STOCK, NB_STOCK) +: 8] <= beat.data;
                        if (in_field(beat.idx, `ITCH_OFS_A_PRICE, NB_PRICE))
                            record.price[lane(beat.idx, `ITCH_OFS_A_PRICE, NB_PRICE) +: 8] <= beat.data;
                    end
                    `ITCH_TYPE_E: begin
                        if (in_field(beat.idx, `ITCH_OFS_E_SHARES, NB_SHARES))
                            record.shares[lane(beat.idx, `ITCH_OFS_E_SHARES, NB_SHARES) +: 8] <= beat.data;
                        if (in_field(beat.idx, `ITCH_OFS_E_MATCH, NB_MATCH))
                            record.match_no[lane(beat.idx, `ITCH_OFS_E_MATCH, NB_MATCH) +: 8] <= beat.data;
                    end
                    `ITCH_TYPE_X: begin
                        if (in_field(beat.idx, `ITCH_OFS_X_SHARES, NB_SHARES))
                            record.shares[lane(beat.idx, `ITCH_OFS_X_SHARES, NB_SHARES) +: 8] <= beat.data;
                    end
                    default: ;  // D carries nothing past the header
                endcase
            end
        end
    end

    // Beats of one message keep the type latched by its first beat
    assert property (@(posedge clk) disable iff (rst)
        beat_strobe && !beat.first |-> beat.msg_type == record.msg_type)
        else $error("assembler saw a type change inside a message");

endmodule

/* hw/itch_framer.sv */
`timescale 1ns/1ps
`include "itch_params.svh"

module itch_framer
    import itch_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  itch_byte_t in,
    output itch_beat_t beat,
    output logic       beat_strobe,
    output logic       abort
);

    itch_byte_t             in_q;    // Input byte, registered once
    logic                   open_q;  // A legal message is being received
    logic [`ITCH_IDX_W-1:0] idx_q;   // Index of the next byte
    logic [`ITCH_IDX_W-1:0] len_q;
    logic [7:0]             type_q;

    logic                   type_ok;
    logic [`ITCH_IDX_W-1:0] start_len;
    logic                   is_last;

    // Length lookup for the type byte of a start
    always_comb begin
        type_ok = 1'b1;
        case (in_q.data)
            `ITCH_TYPE_A: start_len = `ITCH_LEN_A;
            `ITCH_TYPE_D: start_len = `ITCH_LEN_D;
            `ITCH_TYPE_E: start_len = `ITCH_LEN_E;
            `ITCH_TYPE_X: start_len = `ITCH_LEN_X;
            default: begin
                start_len = '0;
                type_ok   = 1'b0;
            end
        endcase
    end

    assign is_last = (idx_q == len_q - 1'b1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            in_q        <= '0;
            open_q      <= 1'b0;
            idx_q       <= '0;
            len_q       <= '0;
            type_q      <= '0;
            beat        <= '0;
            beat_strobe <= 1'b0;
            abort       <= 1'b0;
        end else begin
            in_q        <= in;
            beat_strobe <= 1'b0;
            abort       <= 1'b0;
            if (in_q.valid && in_q.start) begin
                // A restart drops whatever was still open
                abort       <= open_q;
                open_q      <= type_ok;
                idx_q       <= {{(`ITCH_IDX_W-1){1'b0}}, 1'b1};
                len_q       <= start_len;
                type_q      <= in_q.data;
                beat_strobe <= type_ok;  // Illegal types never reach the assembler
                beat.data     <= in_q.data;
                beat.idx      <= '0;
                beat.msg_type <= in_q.data;
                beat.first    <= 1'b1;
                beat.last     <= 1'b0;
            end else if (open_q) begin
                if (!in_q.valid) begin
                    abort  <= 1'b1;
                    open_q <= 1'b0;
                end else begin
                    beat_strobe   <= 1'b1;
                    beat.data     <= in_q.data;
                    beat.idx      <= idx_q;
                    beat.msg_type <= type_q;
                    beat.first    <= 1'b0;
                    beat.last     <= is_last;
                    idx_q         <= idx_q + 1'b1;
                    if (is_last)
                        open_q <= 1'b0;  // Trailing bytes fall through until the next start
                end
            end
        end
    end

    // The counter closes the message before it can run past its length
    assert property (@(posedge clk) disable iff (rst) open_q |-> idx_q < len_q)
        else $error("framer index reached message length");

    // Outside an open message only the beat that just closed it may be on the output
    assert property (@(posedge clk) disable iff (rst) beat_strobe |-> open_q || beat.last)
        else $error("framer emitted a beat while idle");

endmodule

/* hw/itch_msg_emitter.sv */
`timescale 1ns/1ps

module itch_msg_emitter
    import itch_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  itch_msg_t  record,
    input  itch_beat_t beat,
    input  logic       beat_strobe,
    output itch_msg_t  msg,
    output logic       valid_msg
);

    logic last_q;  // Last beat seen, record completes this cycle

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_q <= 1'b0;
        end else begin
            last_q <= beat_strobe && beat.last;
        end
    end

    // The output copy stays put while the assembler works on the next message
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            msg       <= '0;
            valid_msg <= 1'b0;
        end else begin
            valid_msg <= last_q;
            if (last_q)
                msg <= record;
        end
    end

    // Messages are at least 19 bytes long so strobes never touch
    assert property (@(posedge clk) disable iff (rst) valid_msg |=> !valid_msg)
        else $error("valid_msg held high for two cycles");

endmodule

/* hw/itch_parser.sv */
`timescale 1ns/1ps

module itch_parser
    import itch_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  itch_byte_t in,
    output itch_msg_t  msg,
    output logic       valid_msg
);

    itch_beat_t beat;
    logic       beat_strobe;
    logic       abort;
    itch_msg_t  record;  // Message under construction

    itch_framer u_itch_framer (
        .clk         (clk),
        .rst         (rst),
        .in          (in),
        .beat        (beat),
        .beat_strobe (beat_strobe),
        .abort       (abort)
    );

    itch_field_assembler u_itch_field_assembler (
        .clk         (clk),
        .rst         (rst),
        .beat        (beat),
        .beat_strobe (beat_strobe),
        .abort       (abort),
        .record      (record)
    );

    // Sees the last beat directly and never gets one for a dropped message
    itch_msg_emitter u_itch_msg_emitter (
        .clk         (clk),
        .rst         (rst),
        .record      (record),
        .beat        (beat),
        .beat_strobe (beat_strobe),
        .msg         (msg),
        .valid_msg   (valid_msg)
    );

endmodule

/* hw/itch_pkg.sv */
`include "itch_params.svh"

package itch_pkg;

    // One byte of the input stream
    typedef struct packed {
        logic       start;  // Marks the type byte of a new message
        logic       valid;
        logic [7:0] data;
    } itch_byte_t;

    // One accepted message byte, numbered by the framer
    typedef struct packed {
        logic [7:0]             data;
        logic [`ITCH_IDX_W-1:0] idx;       // Position inside the message, type byte is 0
        logic [7:0]             msg_type;
        logic                   first;
        logic                   last;
    } itch_beat_t;

    // Decoded record, fields a type does not carry read zero
    typedef struct packed {
        logic [`ITCH_W_CHAR-1:0]   msg_type;
        logic [`ITCH_W_LOCATE-1:0] stock_locate;
        logic [`ITCH_W_TRACK-1:0]  tracking_no;
        logic [`ITCH_W_TS-1:0]     timestamp;     // Nanoseconds since midnight
        logic [`ITCH_W_REF-1:0]    order_ref_no;
        logic [`ITCH_W_SHARES-1:0] shares;
        logic [`ITCH_W_PRICE-1:0]  price;
        logic [`ITCH_W_CHAR-1:0]   buy_sell;      // ASCII B or S
        logic [`ITCH_W_STOCK-1:0]  stock;         // Symbol, right padded with spaces
        logic [`ITCH_W_MATCH-1:0]  match_no;
    } itch_msg_t;

endpackage

/* include/itch_params.svh */
`ifndef ITCH_PARAMS_SVH
`define ITCH_PARAMS_SVH

// ASCII type codes of the supported messages
`define ITCH_TYPE_A 8'h41
`define ITCH_TYPE_D 8'h44
`define ITCH_TYPE_E 8'h45
`define ITCH_TYPE_X 8'h58

// Total length in bytes, type byte included
`define ITCH_LEN_A 6'd36
`define ITCH_LEN_D 6'd19
`define ITCH_LEN_E 6'd31
`define ITCH_LEN_X 6'd23

`define ITCH_IDX_W    6
`define ITCH_HDR_LAST 6'd18

// First byte index of each field
`define ITCH_OFS_LOCATE    1
`define ITCH_OFS_TRACK     3
`define ITCH_OFS_TS        5
`define ITCH_OFS_REF       11
`define ITCH_OFS_A_BUYSELL 19
`define ITCH_OFS_A_SHARES  20
`define ITCH_OFS_A_STOCK   24
`define ITCH_OFS_A_PRICE   32
`define ITCH_OFS_E_SHARES  19
`define ITCH_OFS_E_MATCH   23
`define ITCH_OFS_X_SHARES  19

// Field widths in bits
`define ITCH_W_CHAR   8
`define ITCH_W_LOCATE 16
`define ITCH_W_TRACK  16
`define ITCH_W_TS     48
`define ITCH_W_REF    64
`define ITCH_W_SHARES 32
`define ITCH_W_PRICE  32
`define ITCH_W_STOCK  64
`define ITCH_W_MATCH  64

`endif

/* itch_parser.f */
+incdir+include
hw/itch_pkg.sv
hw/itch_framer.sv
hw/itch_field_assembler.sv
hw/itch_msg_emitter.sv
hw/itch_parser.sv
test/itch_parser_checker.sv
test/itch_parser_tb.sv

/* test/itch_parser_checker.sv */
`timescale 1ns/1ps
`include "itch_params.svh"

module itch_parser_checker
    import itch_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  itch_byte_t in,
    input  itch_msg_t  msg,
    input  logic       valid_msg,
    input  logic       final_check,
    output int         value_errors,
    output int         protocol_errors
);

    localparam int SEEN_AT = 4;  // Raised by the third edge after the last byte, seen at the fourth

    itch_msg_t        exp_q[$];
    int               due_q[$];
    itch_msg_t        held;      // Output copy that must not move between strobes
    itch_msg_t        expected;
    logic [0:35][7:0] msg_bytes;
    int               nbytes;
    int               want;
    int               cycle;
    int               due;
    logic             open;
    logic             reset_seen = 1'b0;
    int               value_count = 0;
    int               protocol_count = 0;

    assign value_errors    = value_count;
    assign protocol_errors = protocol_count;

    function automatic int msg_len(input logic [7:0] t);
        case (t)
            `ITCH_TYPE_A: return int'(`ITCH_LEN_A);
            `ITCH_TYPE_D: return int'(`ITCH_LEN_D);
            `ITCH_TYPE_E: return int'(`ITCH_LEN_E);
            `ITCH_TYPE_X: return int'(`ITCH_LEN_X);
            default: return 0;  // Dropped at the type byte
        endcase
    endfunction

    // First byte received ends up most significant
    function automatic logic [63:0] be_field(input logic [0:35][7:0] b, input int ofs,
                                             input int nb);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < nb; i++)
            v = {v[55:0], b[ofs + i]};
        return v;
    endfunction

    function automatic itch_msg_t decode_msg(input logic [0:35][7:0] b);
        itch_msg_t m;
        m              = '0;
        m.msg_type     = b[0];
        m.stock_locate = 16'(be_field(b, `ITCH_OFS_LOCATE, 2));
        m.tracking_no  = 16'(be_field(b, `ITCH_OFS_TRACK, 2));
        m.timestamp    = 48'(be_field(b, `ITCH_OFS_TS, 6));
        m.order_ref_no = be_field(b, `ITCH_OFS_REF, 8);
        case (b[0])
            `ITCH_TYPE_A: begin
                m.buy_sell = b[`ITCH_OFS_A_BUYSELL];
                m.shares   = 32'(be_field(b, `ITCH_OFS_A_SHARES, 4));
                m.stock    = be_field(b, `ITCH_OFS_A_STOCK, 8);
                m.price    = 32'(be_field(b, `ITCH_OFS_A_PRICE, 4));
            end
            `ITCH_TYPE_E: begin
                m.shares   = 32'(be_field(b, `ITCH_OFS_E_SHARES, 4));
                m.match_no = be_field(b, `ITCH_OFS_E_MATCH, 8);
            end
            `ITCH_TYPE_X: m.shares = 32'(be_field(b, `ITCH_OFS_X_SHARES, 4));
            default: ;  // D has the header only
        endcase
        return m;
    endfunction

    task automatic check_field(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("FAIL %s expected 0x%h got 0x%h at %0t", name, exp, act, $time);
            value_count++;
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            open  = 1'b0;
            cycle = 0;
            held  = '0;
            // The first reset edge may still find the outputs unset
            if (reset_seen && (valid_msg !== 1'b0 || msg !== '0)) begin
                $display("Error: outputs are not cleared while reset is held (%0t)", $time);
                protocol_count++;
            end
            reset_seen = 1'b1;
        end else begin
            cycle++;
            if (valid_msg === 1'b1) begin
                if (exp_q.size() == 0) begin
                    $display("Error: valid_msg came with no message expected (%0t)", $time);
                    protocol_count++;
                end else begin
                    expected = exp_q.pop_front();
                    due      = due_q.pop_front();
                    if (cycle != due) begin
                        $display("Error: valid_msg seen at cycle %0d instead of %0d", cycle, due);
                        protocol_count++;
                    end
                    check_field("msg_type", 64'(expected.msg_type), 64'(msg.msg_type));
                    check_field("stock_locate", 64'(expected.stock_locate), 64'(msg.stock_locate));
                    check_field("tracking_no", 64'(expected.tracking_no), 64'(msg.tracking_no));
                    check_field("timestamp", 64'(expected.timestamp), 64'(msg.timestamp));
                    check_field("order_ref_no", expected.order_ref_no, msg.order_ref_no);
                    check_field("shares", 64'(expected.shares), 64'(msg.shares));
                    check_field("price", 64'(expected.price), 64'(msg.price));
                    check_field("buy_sell", 64'(expected.buy_sell), 64'(msg.buy_sell));
                    check_field("stock", expected.stock, msg.stock);
                    check_field("match_no", expected.match_no, msg.match_no);
                end
                held = msg;
            end else if (msg !== held) begin
                $display("Error: msg changed without valid_msg (%0t)", $time);
                protocol_count++;
                held = msg;
            end
            // Input side, following the framing and drop rules
            if (in.valid && in.start) begin
                msg_bytes[0] = in.data;  // A restart simply drops the open message
                nbytes       = 1;
                want         = msg_len(in.data);
                open         = (want != 0);
            end else if (open) begin
                if (!in.valid) begin
                    open = 1'b0;
                end else begin
                    msg_bytes[nbytes] = in.data;
                    nbytes++;
                    if (nbytes == want) begin
                        exp_q.push_back(decode_msg(msg_bytes));
                        due_q.push_back(cycle + SEEN_AT);
                        open = 1'b0;
                    end
                end
            end
            if (final_check && exp_q.size() != 0) begin
                $display("Error: %0d expected messages never came out", exp_q.size());
                protocol_count += exp_q.size();
                exp_q.delete();
                due_q.delete();
            end
        end
    end

endmodule

/* test/itch_parser_tb.sv */
`timescale 1ns/1ps
`include "itch_params.svh"

module itch_parser_tb
    import itch_pkg::*;
();

    localparam int CLK_PERIOD = 20;
    // Bytes sent by the four phases below, trailing bytes included
    localparam int TEST_BYTES = 2 * 109 + 145 + 154 + 81;

    logic       clk;
    logic       rst;
    itch_byte_t in;
    itch_msg_t  msg;
    logic       valid_msg;
    logic       final_check;
    int         value_errors;
    int         protocol_errors;
    int         seed;

    itch_parser u_itch_parser (
        .clk       (clk),
        .rst       (rst),
        .in        (in),
        .msg       (msg),
        .valid_msg (valid_msg)
    );

    itch_parser_checker u_checker (
        .clk             (clk),
        .rst             (rst),
        .in              (in),
        .msg             (msg),
        .valid_msg       (valid_msg),
        .final_check     (final_check),
        .value_errors    (value_errors),
        .protocol_errors (protocol_errors)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic drive_byte(input logic start, input logic valid, input logic [7:0] data);
        @(negedge clk);
        in.start = start;
        in.valid = valid;
        in.data  = data;
    endtask

    // Idle gap, then the message, cut to cut bytes when cut is nonzero, then trailing bytes
    task automatic send_msg(input logic [7:0] msg_type, input int gap, input int cut,
                            input int trail);
        int len;
        case (msg_type)
            `ITCH_TYPE_A: len = 36;
            `ITCH_TYPE_D: len = 19;
            `ITCH_TYPE_E: len = 31;
            `ITCH_TYPE_X: len = 23;
            default: len = 20;
        endcase
        if (cut > 0)
            len = cut;
        repeat (gap) drive_byte(1'b0, 1'b0, 8'h00);
        drive_byte(1'b1, 1'b1, msg_type);
        for (int i = 1; i < len + trail; i++)
            drive_byte(1'b0, 1'b1, 8'($random(seed)));
    endtask

    initial begin
        seed        = 8;
        rst         = 1'b1;
        in          = '0;
        final_check = 1'b0;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        repeat (2) begin
            send_msg(`ITCH_TYPE_A, 2, 0, 0);
            send_msg(`ITCH_TYPE_D, 2, 0, 0);
            send_msg(`ITCH_TYPE_E, 2, 0, 0);
            send_msg(`ITCH_TYPE_X, 2, 0, 0);
        end
        // Back to back, every start right after a last byte
        send_msg(`ITCH_TYPE_A, 1, 0, 0);
        send_msg(`ITCH_TYPE_E, 0, 0, 0);
        send_msg(`ITCH_TYPE_X, 0, 0, 0);
        send_msg(`ITCH_TYPE_D, 0, 0, 0);
        send_msg(`ITCH_TYPE_A, 0, 0, 0);
        send_msg(8'h5A, 2, 0, 0);         // Illegal type
        send_msg(`ITCH_TYPE_A, 0, 0, 0);
        send_msg(`ITCH_TYPE_E, 2, 10, 0);  // Valid falls after 10 bytes
        drive_byte(1'b0, 1'b0, 8'h00);
        // Enough bytes to complete the E message if the drop were missed
        repeat (21) drive_byte(1'b0, 1'b1, 8'($random(seed)));
        send_msg(`ITCH_TYPE_X, 1, 0, 0);
        send_msg(`ITCH_TYPE_A, 2, 25, 0);  // Cut short by the next start
        send_msg(`ITCH_TYPE_D, 0, 0, 0);
        // Extra bytes after the last byte
        send_msg(`ITCH_TYPE_D, 2, 0, 5);
        send_msg(`ITCH_TYPE_E, 0, 0, 3);
        send_msg(`ITCH_TYPE_X, 3, 0, 0);
        repeat (10) drive_byte(1'b0, 1'b0, 8'h00);
        final_check = 1'b1;
        repeat (2) @(negedge clk);
        $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors + protocol_errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        #((TEST_BYTES + 100) * CLK_PERIOD);
        $display("Timeout: the stimulus did not finish in time");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule
